//--- conv5x5.f
+incdir+rtl
rtl/conv_data_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/window_if.sv
rtl/ingress_handshake.sv
rtl/line_buffer_5x5.sv
rtl/window_mac.sv
rtl/conv5x5_top.sv
bench/conv5x5_asserts.sv
bench/conv5x5_tb.sv

//--- bench/conv5x5_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv5x5_tb
	import conv_data_pkg::*;
();

	localparam int W = `IMG_WIDTH;
	localparam int OLD_EXTRA = 10;
	localparam int TOTAL_WORDS = 4 * `KTAPS + W * (6 + 7 + 6 + 5 + 6) + OLD_EXTRA;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 200;

	typedef logic signed [63:0] val_t;

	logic        clk;
	logic        reset;
	in_word_t    in_word;
	logic        in_req;
	logic        in_ack;
	acc_t        result;
	logic        result_req;
	logic        result_ack;

	int          checks;
	int          errors;
	int          ack_delay_max;
	logic        bp_watch;
	logic [31:0] data_state;
	logic [31:0] delay_state;
	val_t        exp_q [$];
	val_t        got_q [$];
	coef_t       wmod [`KTAPS];
	pixel_t      img [8][W];
	int          mrow;
	int          mcol;

	conv5x5_top DUT (
		.clk        (clk),
		.reset      (reset),
		.in_word    (in_word),
		.in_req     (in_req),
		.in_ack     (in_ack),
		.result     (result),
		.result_req (result_req),
		.result_ack (result_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pixel_t ramp_pixel(input int r, input int c);
		return pixel_t'(r * W + c + 1);
	endfunction

	task automatic check_value(input string name, input val_t expected, input val_t actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// ========================================================================
	// reference model, windows in raster order with tap k times weight k
	// ========================================================================

	task automatic model_pixel(input pixel_t pix, input logic fs);
		val_t acc;
		if (fs)
		begin
			mrow = 0;
			mcol = 0;
		end
		img[mrow][mcol] = pix;
		if ((mrow >= 4) && (mcol >= 4))
		begin
			acc = 0;
			for (int i = 0; i < 5; i++)
			begin
				for (int j = 0; j < 5; j++)
				begin
					acc += val_t'(img[mrow-4+i][mcol-4+j]) * val_t'(wmod[5*i+j]);
				end
			end
			exp_q.push_back(val_t'(acc_t'(acc)));
		end
		if (mcol == W - 1)
		begin
			mcol = 0;
			mrow++;
		end
		else
		begin
			mcol++;
		end
	endtask

	// ========================================================================
	// four-phase drivers
	// ========================================================================

	task automatic send_word(input in_word_t w);
		@(negedge clk);
		in_word = w;
		in_req  = 1'b1;
		while (!in_ack)
		begin
			@(negedge clk);
		end
		in_req = 1'b0;
		while (in_ack)
		begin
			@(negedge clk);
		end
	endtask

	task automatic send_weight(input int idx, input coef_t coef);
		in_word_t w;
		w = '0;
		w.kind = 1'b1;
		w.payload.wgt.idx  = idx[4:0];
		w.payload.wgt.coef = coef;
		wmod[idx] = coef;
		send_word(w);
	endtask

	task automatic send_pixel(input pixel_t pix, input logic fs);
		in_word_t w;
		w = '0;
		w.kind = 1'b0;
		w.payload.pix.frame_start = fs;
		w.payload.pix.pixel       = pix;
		model_pixel(pix, fs);
		send_word(w);
	endtask

	task automatic send_random_frame(input int n_pix);
		for (int p = 0; p < n_pix; p++)
		begin
			data_state = lcg_next(data_state);
			send_pixel(pixel_t'(data_state[31:16]), p == 0);
		end
	endtask

	task automatic load_random_weights();
		for (int k = 0; k < `KTAPS; k++)
		begin
			data_state = lcg_next(data_state);
			send_weight(k, coef_t'(data_state[31:16]));
		end
	endtask

	// acknowledges each result after a delay of up to ack_delay_max cycles
	task automatic collect_results();
		int wait_cycles;
		forever
		begin
			@(negedge clk);
			if (result_req && !result_ack)
			begin
				got_q.push_back(val_t'(result));
				wait_cycles = 0;
				if (ack_delay_max > 0)
				begin
					delay_state = lcg_next(delay_state);
					wait_cycles = delay_state[31:16] % (ack_delay_max + 1);
				end
				repeat (wait_cycles) @(negedge clk);
				result_ack = 1'b1;
				while (result_req)
				begin
					@(negedge clk);
				end
				result_ack = 1'b0;
			end
		end
	endtask

	task automatic drain_results();
		while (got_q.size() < exp_q.size())
		begin
			@(negedge clk);
		end
		// room for a stray result from the last pixel
		repeat (8) @(negedge clk);
	endtask

	task automatic compare_results(input string name);
		int n;
		check_value({name, " count"}, exp_q.size(), got_q.size());
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int k = 0; k < n; k++)
		begin
			check_value(name, exp_q[k], got_q[k]);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%-12s done: %0d results, %0d errors", name, got_q.size(), errors - err_before);
		exp_q.delete();
		got_q.delete();
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================

	task automatic test_reset_idle();
		int e0;
		e0 = errors;
		check_value("reset_idle in_ack", 0, in_ack);
		check_value("reset_idle result_req", 0, result_req);
		load_random_weights();
		drain_results();
		compare_results("reset_idle");
		report_test("reset_idle", e0);
	endtask

	task automatic test_center_tap();
		int e0;
		e0 = errors;
		for (int k = 0; k < `KTAPS; k++)
		begin
			send_weight(k, (k == 12) ? coef_t'(1) : coef_t'(0));
		end
		for (int p = 0; p < 6 * W; p++)
		begin
			send_pixel(ramp_pixel(p / W, p % W), p == 0);
		end
		drain_results();
		compare_results("center_tap");
		check_value("center_tap windows", 2 * (W - 4), got_q.size());
		// result n belongs to the window whose newest pixel is (4 + n/(W-4), 4 + n%(W-4))
		for (int n = 0; n < got_q.size(); n++)
		begin
			check_value("center_tap pixel", ramp_pixel(2 + n / (W - 4), 2 + n % (W - 4)), got_q[n]);
		end
		report_test("center_tap", e0);
	endtask

	task automatic test_random();
		int e0;
		e0 = errors;
		load_random_weights();
		send_random_frame(7 * W);
		drain_results();
		compare_results("random");
		report_test("random", e0);
	endtask

	task automatic test_backpressure();
		int e0;
		e0 = errors;
		ack_delay_max = 7;
		bp_watch = 1'b1;
		send_random_frame(6 * W);
		drain_results();
		bp_watch = 1'b0;
		ack_delay_max = 0;
		compare_results("backpressure");
		report_test("backpressure", e0);
	endtask

	task automatic test_restart();
		int e0;
		e0 = errors;
		load_random_weights();
		send_random_frame(5 * W + OLD_EXTRA);
		send_random_frame(6 * W);
		drain_results();
		compare_results("restart");
		check_value("restart windows", 3 * (W - 4) + OLD_EXTRA - 4, got_q.size());
		report_test("restart", e0);
	endtask

	// a pixel may not be acknowledged while a result is still outstanding
	initial
	begin : ack_monitor
		logic ack_q;
		ack_q = 1'b0;
		forever
		begin
			@(negedge clk);
			if (bp_watch && in_ack && !ack_q && !in_word.kind)
			begin
				check_value("backpressure result_req", 0, result_req);
				check_value("backpressure result_ack", 0, result_ack);
			end
			ack_q = in_ack;
		end
	end

	initial
	begin
		collect_results();
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		in_word       = '0;
		in_req        = 1'b0;
		result_ack    = 1'b0;
		reset         = 1'b1;
		checks        = 0;
		errors        = 0;
		ack_delay_max = 0;
		bp_watch      = 1'b0;
		data_state    = 32'h9937;
		delay_state   = 32'h9937;
		mrow          = 0;
		mcol          = 0;
		for (int k = 0; k < `KTAPS; k++)
		begin
			wmod[k] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset_idle();
		test_center_tap();
		test_random();
		test_backpressure();
		test_restart();

		errors = errors + DUT.u_asserts.fail_count;
		$display("summary: %0d checks, %0d errors including %0d assertion failures",
			checks, errors, DUT.u_asserts.fail_count);
		if (errors == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/conv5x5_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv5x5_asserts
	import conv_data_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              in_req,
	input  wire logic              in_ack,
	input  acc_t                   result,
	input  wire logic              result_req,
	input  wire logic              result_ack,
	input  wire logic              shift_en,
	input  wire logic              frame_start,
	input  wire logic              win_valid,
	input  wire logic [`ROW_W-1:0] pix_row,
	input  wire logic [`ROW_W-1:0] pix_col
);

	// read by the testbench at the end of the run
	int fail_count;

	// pixels received since the last frame start, the newest one included
	int frame_pix;

	initial
	begin
		fail_count = 0;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			frame_pix <= 0;
		end
		else if (shift_en)
		begin
			frame_pix <= frame_start ? 1 : frame_pix + 1;
		end
	end

	// in_ack rises on the edge after the request was seen
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> $past(in_req))
	else
	begin
		fail_count++;
		$error("in_ack rose while in_req was low");
	end

	result_held: assert property (@(posedge clk) disable iff (reset)
		(result_req && $past(result_req)) |-> $stable(result))
	else
	begin
		fail_count++;
		$error("result changed while result_req was high");
	end

	// the sender may only release the request after it has been acknowledged
	req_waits_ack: assert property (@(posedge clk) disable iff (reset)
		$fell(result_req) |-> $past(result_ack))
	else
	begin
		fail_count++;
		$error("result_req fell before result_ack");
	end

	window_inside: assert property (@(posedge clk) disable iff (reset)
		win_valid |-> (pix_row >= 4) && (pix_col >= 4)
			&& (pix_row == (frame_pix - 1) / `IMG_WIDTH)
			&& (pix_col == (frame_pix - 1) % `IMG_WIDTH))
	else
	begin
		fail_count++;
		$error("win_valid raised for a window outside the image");
	end

endmodule

bind conv5x5_top conv5x5_asserts u_asserts (
	.clk         (clk),
	.reset       (reset),
	.in_req      (in_req),
	.in_ack      (in_ack),
	.result      (result),
	.result_req  (result_req),
	.result_ack  (result_ack),
	.shift_en    (shift_en),
	.frame_start (frame_start),
	.win_valid   (win.win_valid),
	.pix_row     (win.pix_row),
	.pix_col     (win.pix_col)
);

`default_nettype wire

//--- rtl/conv5x5_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv5x5_top
	import conv_data_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  in_word_t  in_word,
	input  wire logic in_req,
	output logic      in_ack,
	output acc_t      result,
	output logic      result_req,
	input  wire logic result_ack
);

	logic       shift_en;
	pixel_t     shift_pix;
	logic       frame_start;
	logic       wgt_we;
	logic [4:0] wgt_idx;
	coef_t      wgt_val;
	logic       mac_ready;

	window_if win ();

	ingress_handshake u_ingress (
		.clk         (clk),
		.reset       (reset),
		.in_word     (in_word),
		.in_req      (in_req),
		.mac_ready   (mac_ready),
		.in_ack      (in_ack),
		.shift_en    (shift_en),
		.shift_pix   (shift_pix),
		.frame_start (frame_start),
		.wgt_we      (wgt_we),
		.wgt_idx     (wgt_idx),
		.wgt_val     (wgt_val)
	);

	line_buffer_5x5 u_line_buffer (
		.clk         (clk),
		.reset       (reset),
		.shift_en    (shift_en),
		.shift_pix   (shift_pix),
		.frame_start (frame_start),
		.win         (win.producer)
	);

	window_mac u_mac (
		.clk         (clk),
		.reset       (reset),
		.win         (win.consumer),
		.wgt_we      (wgt_we),
		.wgt_idx     (wgt_idx),
		.wgt_val     (wgt_val),
		.result_ack  (result_ack),
		.result      (result),
		.result_req  (result_req),
		.mac_ready   (mac_ready)
	);

endmodule

`default_nettype wire

//--- rtl/window_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module window_mac
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	window_if.consumer win,
	input  wire logic  wgt_we,
	input  wire logic  [4:0] wgt_idx,
	input  coef_t      wgt_val,
	input  wire logic  result_ack,
	output acc_t       result,
	output logic       result_req,
	output logic       mac_ready
);

	mac_state_t state;
	coef_t      weights [`KTAPS];
	logic signed [`PIX_W+`COEF_W-1:0] prod_q [`KTAPS];
	acc_t       sum_c;

	// ========================================================================
	// weight store
	// ========================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int k = 0; k < `KTAPS; k++)
			begin
				weights[k] <= '0;
			end
		end
		else if (wgt_we && (wgt_idx < `KTAPS))
		begin
			weights[wgt_idx] <= wgt_val;
		end
	end

	// ========================================================================
	// product and sum stages
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if ((state == MAC_EMPTY) && win.win_valid)
		begin
			for (int k = 0; k < `KTAPS; k++)
			begin
				prod_q[k] <= win.taps[k] * weights[k];
			end
		end
	end

	// products are sign extended before the adder tree
	always_comb
	begin
		sum_c = '0;
		for (int k = 0; k < `KTAPS; k++)
		begin
			sum_c = sum_c + acc_t'(prod_q[k]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == MAC_PRODUCT)
		begin
			result <= sum_c;
		end
	end

	// ========================================================================
	// occupancy and four-phase send
	// ========================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= MAC_EMPTY;
			result_req <= 1'b0;
		end
		else
		begin
			case (state)
				MAC_EMPTY:
				begin
					if (win.win_valid)
					begin
						state <= MAC_PRODUCT;
					end
				end
				MAC_PRODUCT:
				begin
					state <= MAC_SUM;
				end
				MAC_SUM:
				begin
					result_req <= 1'b1;
					state      <= MAC_HOLD;
				end
				MAC_HOLD:
				begin
					if (result_req && result_ack)
					begin
						result_req <= 1'b0;
					end
					// wait for the receiver to release ack before the next result
					else if (!result_req && !result_ack)
					begin
						state <= MAC_EMPTY;
					end
				end
				default:
				begin
					state <= MAC_EMPTY;
				end
			endcase
		end
	end

	assign mac_ready = (state == MAC_EMPTY) && !win.win_valid;

endmodule

`default_nettype wire

//--- rtl/line_buffer_5x5.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module line_buffer_5x5
	import conv_data_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  shift_en,
	input  pixel_t     shift_pix,
	input  wire logic  frame_start,
	window_if.producer win
);

	localparam int DEPTH = 4 * `IMG_WIDTH + 5;

	pixel_t            stages [DEPTH];
	logic [`ROW_W-1:0] nxt_row;
	logic [`ROW_W-1:0] nxt_col;
	logic [`ROW_W-1:0] cur_row;
	logic [`ROW_W-1:0] cur_col;

	// stage 0 holds the newest pixel
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < DEPTH; s++)
			begin
				stages[s] <= '0;
			end
		end
		else if (shift_en)
		begin
			stages[0] <= shift_pix;
			for (int s = 1; s < DEPTH; s++)
			begin
				stages[s] <= stages[s-1];
			end
		end
	end

	// kernel row 0 is the oldest row, column 0 the leftmost pixel
	for (genvar i = 0; i < 5; i++)
	begin : g_row
		for (genvar j = 0; j < 5; j++)
		begin : g_col
			assign win.taps[5*i+j] = stages[(4-i)*`IMG_WIDTH + (4-j)];
		end
	end

	// ========================================================================
	// position of the incoming pixel and window-valid detection
	// ========================================================================

	assign cur_row = frame_start ? '0 : nxt_row;
	assign cur_col = frame_start ? '0 : nxt_col;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			nxt_row       <= '0;
			nxt_col       <= '0;
			win.pix_row   <= '0;
			win.pix_col   <= '0;
			win.win_valid <= 1'b0;
		end
		else
		begin
			win.win_valid <= shift_en && (cur_row >= 4) && (cur_col >= 4);
			if (shift_en)
			begin
				win.pix_row <= cur_row;
				win.pix_col <= cur_col;
				if (cur_col == `IMG_WIDTH - 1)
				begin
					nxt_col <= '0;
					// saturate so a very long stream keeps producing windows
					nxt_row <= (cur_row == '1) ? cur_row : cur_row + 1'b1;
				end
				else
				begin
					nxt_col <= cur_col + 1'b1;
					nxt_row <= cur_row;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/ingress_handshake.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_handshake
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  in_word_t    in_word,
	input  wire logic   in_req,
	input  wire logic   mac_ready,
	output logic        in_ack,
	output logic        shift_en,
	output pixel_t      shift_pix,
	output logic        frame_start,
	output logic        wgt_we,
	output logic [4:0]  wgt_idx,
	output coef_t       wgt_val
);

	hs_state_t state;
	logic      req_seen;
	logic      accept_pix;
	logic      accept_wgt;

	// ========================================================================
	// word decode and acceptance
	// ========================================================================

	assign req_seen = (state == HS_IDLE) && in_req;

	// pixels wait while the multiply-accumulate is busy, weights never wait
	assign accept_pix = req_seen && !in_word.kind && mac_ready;
	assign accept_wgt = req_seen && in_word.kind;

	assign shift_en    = accept_pix;
	assign shift_pix   = in_word.payload.pix.pixel;
	assign frame_start = in_word.payload.pix.frame_start;

	assign wgt_we  = accept_wgt;
	assign wgt_idx = in_word.payload.wgt.idx;
	assign wgt_val = in_word.payload.wgt.coef;

	// ========================================================================
	// four-phase receive sequencing
	// ========================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= HS_IDLE;
		end
		else
		begin
			case (state)
				HS_IDLE:
				begin
					if (accept_pix || accept_wgt)
					begin
						state <= HS_ACKED;
					end
				end
				HS_ACKED:
				begin
					// sender has released the word, close the cycle
					if (!in_req)
					begin
						state <= HS_IDLE;
					end
				end
				default:
				begin
					state <= HS_IDLE;
				end
			endcase
		end
	end

	assign in_ack = (state == HS_ACKED);

endmodule

`default_nettype wire

//--- rtl/window_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

interface window_if
	import conv_data_pkg::*;
();

	pixel_t           taps [`KTAPS];
	logic             win_valid;
	// position of the newest pixel in the window
	logic [`ROW_W-1:0] pix_row;
	logic [`ROW_W-1:0] pix_col;

	modport producer (
		output taps, win_valid, pix_row, pix_col
	);

	modport consumer (
		input taps, win_valid
	);

endinterface

`default_nettype wire

//--- rtl/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;

	// receive side of the input four-phase port
	typedef enum logic {
		HS_IDLE,
		HS_ACKED
	} hs_state_t;

	// occupancy of the multiply-accumulate pipeline
	typedef enum logic [1:0] {
		MAC_EMPTY,
		MAC_PRODUCT,
		MAC_SUM,
		MAC_HOLD
	} mac_state_t;

endpackage

`default_nettype wire

//--- rtl/conv_data_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package conv_data_pkg;

	typedef logic signed [`PIX_W-1:0]  pixel_t;
	typedef logic signed [`COEF_W-1:0] coef_t;
	typedef logic signed [`ACC_W-1:0]  acc_t;

	// pixel form of the 31-bit payload
	typedef struct packed {
		logic                      frame_start;
		logic [30-`PIX_W-1:0]      spare;
		pixel_t                    pixel;
	} pix_word_t;

	// weight form of the same payload, tap index is 5*row + col
	typedef struct packed {
		logic [31-5-`COEF_W-1:0]   spare;
		logic [4:0]                idx;
		coef_t                     coef;
	} wgt_word_t;

	typedef union packed {
		pix_word_t pix;
		wgt_word_t wgt;
	} in_payload_u;

	// kind 0 is a pixel and kind 1 a weight entry
	typedef struct packed {
		logic        kind;
		in_payload_u payload;
	} in_word_t;

endpackage

`default_nettype wire

//--- rtl/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// image geometry, only the row length is adjustable
`define IMG_WIDTH 30

// datapath widths
`define PIX_W  16
`define COEF_W 16
`define ACC_W  40

// kernel is always 5x5
`define KTAPS 25

// row and column counters in the line buffer
`define ROW_W 10

`endif
